//--- include/policer_config.svh
/* sizing for the policer; POLICER_NUM_PORTS must be a power of two above one
   and POLICER_LEAK_PERIOD at least two */
`ifndef POLICER_CONFIG_SVH
`define POLICER_CONFIG_SVH

// ingress ports served by the policer
`define POLICER_NUM_PORTS 4

// bucket fill counter in bytes
`define POLICER_BUCKET_W 16

// byte length carried on the first beat
`define POLICER_LEN_W 12

// stream data width
`define POLICER_DATA_W 32

// cycles between the starts of two leak sweeps
`define POLICER_LEAK_PERIOD 16

`endif

//--- logic/policer_pkg.sv
/* types shared by the policer blocks; widths come from the config header
   and POLICER_LEN_W must not exceed POLICER_BUCKET_W */
`default_nettype none

`include "policer_config.svh"

package policer_pkg;

    typedef logic [$clog2(`POLICER_NUM_PORTS)-1:0] port_t;
    typedef logic [`POLICER_LEN_W-1:0]              len_t;
    typedef logic [`POLICER_BUCKET_W-1:0]           bucket_t;

    // port and len only mean something on the first beat of a packet
    typedef struct packed {
        logic [`POLICER_DATA_W-1:0] data;
        logic                       last;
        port_t                      port;
        len_t                       len;
    } in_beat_t;

    // drop mark repeats on every beat of a marked packet
    typedef struct packed {
        logic [`POLICER_DATA_W-1:0] data;
        logic                       last;
        logic                       drop;
    } out_beat_t;

endpackage

`default_nettype wire

//--- logic/stream_stage.sv
/* single-entry register slice; takes a new beat when empty or when the held
   beat leaves in the same cycle, so throughput is one beat per cycle */
`timescale 1ns/10ps
`default_nettype none

module stream_stage #(
    parameter type payload_t = logic
) (
    input  wire logic packet_in,
    input  wire logic rst_n,

    input  wire logic up_valid,
    output logic      up_ready,
    input  payload_t  up_data,

    output logic      down_valid,
    input  wire logic down_ready,
    output payload_t  down_data
);

    logic load;

    assign up_ready = !down_valid || down_ready;
    assign load     = up_valid && up_ready;

    always_ff @(posedge packet_in or negedge rst_n) begin
        if (!rst_n) begin
            down_valid <= 1'b0;
        end else if (load) begin
            down_valid <= 1'b1;
        end else if (down_ready) begin
            down_valid <= 1'b0;
        end
    end

    // payload only moves with a load
    always_ff @(posedge packet_in) begin
        if (load) begin
            down_data <= up_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/bucket_table.sv
/* one bucket register per port; read is combinational from addr, and a write
   to the same addr lands at the next edge */
`timescale 1ns/10ps
`default_nettype none

`include "policer_config.svh"

module bucket_table (
    input  wire logic              packet_in,
    input  wire logic              rst_n,
    input  policer_pkg::port_t     addr,
    output policer_pkg::bucket_t   rd_data,
    input  wire logic              wr_en,
    input  policer_pkg::bucket_t   wr_data
);

    policer_pkg::bucket_t bucket [`POLICER_NUM_PORTS-1:0];

    assign rd_data = bucket[addr];

    // all buckets start empty
    always_ff @(posedge packet_in or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `POLICER_NUM_PORTS; i++) begin
                bucket[i] <= '0;
            end
        end else if (wr_en) begin
            bucket[addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/bucket_arbiter.sv
/* fixed priority to the policer, which is always granted in its own cycle;
   the leak engine waits and its write is dropped while it loses */
`timescale 1ns/10ps
`default_nettype none

module bucket_arbiter (
    // policer side
    input  wire logic            p_req,
    input  policer_pkg::port_t   p_addr,
    input  wire logic            p_wr_en,
    input  policer_pkg::bucket_t p_wr_data,
    output logic                 p_gnt,

    // leak engine side
    input  wire logic            l_req,
    input  policer_pkg::port_t   l_addr,
    input  wire logic            l_wr_en,
    input  policer_pkg::bucket_t l_wr_data,
    output logic                 l_gnt,

    // toward the table
    output policer_pkg::port_t   addr,
    output logic                 wr_en,
    output policer_pkg::bucket_t wr_data
);

    assign p_gnt = p_req;
    assign l_gnt = l_req && !p_req;

    always_comb begin
        if (p_req) begin
            addr    = p_addr;
            wr_en   = p_wr_en;
            wr_data = p_wr_data;
        end else begin
            // idle cycles still point the table at the leak address
            addr    = l_addr;
            wr_en   = l_gnt && l_wr_en;
            wr_data = l_wr_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/leak_engine.sv
/* one sweep per POLICER_LEAK_PERIOD cycles, one port per granted cycle; a
   period tick that comes while a sweep is still waiting for grants is skipped */
`timescale 1ns/10ps
`default_nettype none

`include "policer_config.svh"

module leak_engine (
    input  wire logic                       packet_in,
    input  wire logic                       rst_n,
    input  wire logic [`POLICER_NUM_PORTS-1:0] enable,
    input  policer_pkg::bucket_t            decrement [`POLICER_NUM_PORTS-1:0],
    output logic                            req,
    output policer_pkg::port_t              addr,
    output logic                            wr_en,
    output policer_pkg::bucket_t            wr_data,
    input  wire logic                       gnt,
    input  policer_pkg::bucket_t            rd_data
);

    localparam int CNT_W = $clog2(`POLICER_LEAK_PERIOD);

    logic [CNT_W-1:0]   period_cnt;
    logic               tick;
    logic               active;
    policer_pkg::port_t idx;

    assign tick = (period_cnt == CNT_W'(`POLICER_LEAK_PERIOD - 1));

    always_ff @(posedge packet_in or negedge rst_n) begin
        if (!rst_n) begin
            period_cnt <= '0;
        end else if (tick) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // sweep walks ports 0 to N-1, advancing only on a grant
    always_ff @(posedge packet_in or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (!active) begin
            active <= tick;
            idx    <= '0;
        end else if (gnt) begin
            idx <= idx + 1'b1;
            if (idx == policer_pkg::port_t'(`POLICER_NUM_PORTS - 1)) begin
                active <= 1'b0;
            end
        end
    end

    assign req   = active;
    assign addr  = idx;
    assign wr_en = active;

    // drain and floor at zero, disabled ports forced empty
    always_comb begin
        if (!enable[idx]) begin
            wr_data = '0;
        end else if (rd_data > decrement[idx]) begin
            wr_data = rd_data - decrement[idx];
        end else begin
            wr_data = '0;
        end
    end

endmodule

`default_nettype wire

//--- logic/policer_check.sv
/* acts on the stage 1 to stage 2 transfer; the first beat of a packet reads
   and charges its bucket in that cycle and the mark holds until last */
`timescale 1ns/10ps
`default_nettype none

`include "policer_config.svh"

module policer_check (
    input  wire logic                       packet_in,
    input  wire logic                       rst_n,
    input  wire logic                       xfer,
    input  policer_pkg::in_beat_t           beat,
    input  wire logic [`POLICER_NUM_PORTS-1:0] enable,
    input  policer_pkg::bucket_t            threshold [`POLICER_NUM_PORTS-1:0],
    output logic                            req,
    output policer_pkg::port_t              addr,
    output logic                            wr_en,
    output policer_pkg::bucket_t            wr_data,
    input  wire logic                       gnt,
    input  policer_pkg::bucket_t            rd_data,
    output logic                            drop
);

    localparam int BW = `POLICER_BUCKET_W;

    logic          sop;
    logic          drop_hold;
    logic          granted;
    logic          port_en;
    logic [BW:0]   sum;
    logic          over;
    logic          drop_now;

    // only a first beat touches the table
    assign req     = xfer && sop;
    assign addr    = beat.port;
    assign granted = req && gnt;
    assign port_en = enable[beat.port];

    // one spare bit so the sum cannot wrap
    assign sum  = {1'b0, rd_data} + (BW + 1)'(beat.len);
    assign over = port_en && (sum > {1'b0, threshold[beat.port]});

    assign drop_now = granted && over;

    // marked packets leave the bucket alone
    assign wr_en = granted && !over;

    always_comb begin
        if (!port_en) begin
            wr_data = '0;
        end else if (sum[BW]) begin
            wr_data = '1;
        end else begin
            wr_data = sum[BW-1:0];
        end
    end

    assign drop = sop ? drop_now : drop_hold;

    always_ff @(posedge packet_in or negedge rst_n) begin
        if (!rst_n) begin
            sop       <= 1'b1;
            drop_hold <= 1'b0;
        end else if (xfer) begin
            sop <= beat.last;
            if (sop) begin
                drop_hold <= drop_now;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/policer_top.sv
/* two-stage policer pipeline; in_port and in_len are used on first beats only
   and packets are marked, never dropped, here */
`timescale 1ns/10ps
`default_nettype none

`include "policer_config.svh"

module policer_top (
    input  wire logic                       packet_in,
    input  wire logic                       rst_n,

    input  wire logic                       in_valid,
    output logic                            in_ready,
    input  wire logic [`POLICER_DATA_W-1:0] in_data,
    input  wire logic                       in_last,
    input  policer_pkg::port_t              in_port,
    input  policer_pkg::len_t               in_len,

    output logic                            out_valid,
    input  wire logic                       out_ready,
    output logic [`POLICER_DATA_W-1:0]      out_data,
    output logic                            out_last,
    output logic                            out_drop,

    input  wire logic [`POLICER_NUM_PORTS-1:0] enable,
    input  policer_pkg::bucket_t            decrement [`POLICER_NUM_PORTS-1:0],
    input  policer_pkg::bucket_t            threshold [`POLICER_NUM_PORTS-1:0]
);

    policer_pkg::in_beat_t  s1_in;
    policer_pkg::in_beat_t  s1_beat;
    logic                   s1_valid;
    policer_pkg::out_beat_t s2_in;
    policer_pkg::out_beat_t s2_beat;
    logic                   s2_ready;
    logic                   xfer;
    logic                   drop;

    // table access wiring
    logic                 p_req;
    policer_pkg::port_t   p_addr;
    logic                 p_wr_en;
    policer_pkg::bucket_t p_wr_data;
    logic                 p_gnt;
    logic                 l_req;
    policer_pkg::port_t   l_addr;
    logic                 l_wr_en;
    policer_pkg::bucket_t l_wr_data;
    logic                 l_gnt;
    policer_pkg::port_t   t_addr;
    logic                 t_wr_en;
    policer_pkg::bucket_t t_wr_data;
    policer_pkg::bucket_t t_rd_data;

    assign s1_in = '{data: in_data, last: in_last, port: in_port, len: in_len};

    stream_stage #(.payload_t(policer_pkg::in_beat_t)) stage1 (
        .packet_in  (packet_in),
        .rst_n      (rst_n),
        .up_valid   (in_valid),
        .up_ready   (in_ready),
        .up_data    (s1_in),
        .down_valid (s1_valid),
        .down_ready (s2_ready),
        .down_data  (s1_beat)
    );

    // decision happens on this hop
    assign xfer  = s1_valid && s2_ready;
    assign s2_in = '{data: s1_beat.data, last: s1_beat.last, drop: drop};

    stream_stage #(.payload_t(policer_pkg::out_beat_t)) stage2 (
        .packet_in  (packet_in),
        .rst_n      (rst_n),
        .up_valid   (s1_valid),
        .up_ready   (s2_ready),
        .up_data    (s2_in),
        .down_valid (out_valid),
        .down_ready (out_ready),
        .down_data  (s2_beat)
    );

    assign out_data = s2_beat.data;
    assign out_last = s2_beat.last;
    assign out_drop = s2_beat.drop;

    policer_check check0 (
        .packet_in (packet_in),
        .rst_n     (rst_n),
        .xfer      (xfer),
        .beat      (s1_beat),
        .enable    (enable),
        .threshold (threshold),
        .req       (p_req),
        .addr      (p_addr),
        .wr_en     (p_wr_en),
        .wr_data   (p_wr_data),
        .gnt       (p_gnt),
        .rd_data   (t_rd_data),
        .drop      (drop)
    );

    leak_engine leak0 (
        .packet_in (packet_in),
        .rst_n     (rst_n),
        .enable    (enable),
        .decrement (decrement),
        .req       (l_req),
        .addr      (l_addr),
        .wr_en     (l_wr_en),
        .wr_data   (l_wr_data),
        .gnt       (l_gnt),
        .rd_data   (t_rd_data)
    );

    bucket_arbiter arb0 (
        .p_req     (p_req),
        .p_addr    (p_addr),
        .p_wr_en   (p_wr_en),
        .p_wr_data (p_wr_data),
        .p_gnt     (p_gnt),
        .l_req     (l_req),
        .l_addr    (l_addr),
        .l_wr_en   (l_wr_en),
        .l_wr_data (l_wr_data),
        .l_gnt     (l_gnt),
        .addr      (t_addr),
        .wr_en     (t_wr_en),
        .wr_data   (t_wr_data)
    );

    bucket_table table0 (
        .packet_in (packet_in),
        .rst_n     (rst_n),
        .addr      (t_addr),
        .rd_data   (t_rd_data),
        .wr_en     (t_wr_en),
        .wr_data   (t_wr_data)
    );

endmodule

`default_nettype wire

//--- test/policer_monitor.sv
/* compares policer_top outputs with a bucket model; the leak is modelled only
   for a decrement that empties a bucket in one sweep */
`timescale 1ns/10ps
`default_nettype none

`include "policer_config.svh"

module policer_monitor (
    input  wire logic                          packet_in,
    input  wire logic                          rst_n,
    input  wire logic                          in_valid,
    input  wire logic                          in_ready,
    input  wire logic [`POLICER_DATA_W-1:0]    in_data,
    input  wire logic                          in_last,
    input  policer_pkg::port_t                 in_port,
    input  policer_pkg::len_t                  in_len,
    input  wire logic                          out_valid,
    input  wire logic                          out_ready,
    input  wire logic [`POLICER_DATA_W-1:0]    out_data,
    input  wire logic                          out_last,
    input  wire logic                          out_drop,
    input  wire logic [`POLICER_NUM_PORTS-1:0] enable,
    input  policer_pkg::bucket_t               decrement [`POLICER_NUM_PORTS-1:0],
    input  policer_pkg::bucket_t               threshold [`POLICER_NUM_PORTS-1:0],
    input  wire logic                          test_done,
    input  int                                 test_id,
    input  wire logic                          report,
    output int                                 err_count
);

    localparam int NP   = `POLICER_NUM_PORTS;
    localparam int DW   = `POLICER_DATA_W;
    localparam int FULL = (1 << `POLICER_BUCKET_W) - 1;
    // long enough that a whole sweep has run with the held setting
    localparam int SETTLE = 2 * `POLICER_LEAK_PERIOD;

    int            bucket   [NP];
    int            dec_hold [NP];
    int            off_hold [NP];
    logic [DW+1:0] expected [$];
    logic [DW+1:0] exp_beat;
    logic          sop;
    logic          pkt_drop;
    int            fill;
    int            beats;
    int            marked;
    int            test_errs;
    int            total_beats;
    int            tests_run;

    function automatic string test_name(input int id);
        case (id)
            1:       return "accumulation";
            2:       return "port isolation";
            3:       return "disabled port";
            4:       return "leak";
            5:       return "back-pressure";
            default: return "unknown";
        endcase
    endfunction

    task automatic count_error;
        test_errs = test_errs + 1;
        err_count = err_count + 1;
    endtask

    task automatic check_value(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] want);
        if (got !== want) begin
            $display("FAIL %s: got 0x%0h expected 0x%0h in test %0d",
                     name, got, want, test_id);
            count_error();
        end
    endtask

    // a large held decrement or a held disable empties the bucket
    task automatic update_leak;
        for (int p = 0; p < NP; p++) begin
            dec_hold[p] = (decrement[p] != '0) ? dec_hold[p] + 1 : 0;
            off_hold[p] = enable[p] ? 0 : off_hold[p] + 1;
            if (dec_hold[p] >= SETTLE && int'(decrement[p]) >= bucket[p]) begin
                bucket[p] = 0;
            end
            if (off_hold[p] >= SETTLE) begin
                bucket[p] = 0;
            end
        end
    endtask

    task automatic take_input;
        if (sop) begin
            pkt_drop = 1'b0;
            if (!enable[in_port]) begin
                bucket[in_port] = 0;
            end else begin
                fill = bucket[in_port] + int'(in_len);
                if (fill > int'(threshold[in_port])) begin
                    pkt_drop = 1'b1;
                end else begin
                    bucket[in_port] = (fill > FULL) ? FULL : fill;
                end
            end
        end
        expected.push_back({in_data, in_last, pkt_drop});
        sop = in_last;
    endtask

    task automatic check_output;
        if (expected.size() == 0) begin
            $display("output beat appeared with no input beat left to match in test %0d",
                     test_id);
            count_error();
        end else begin
            exp_beat = expected.pop_front();
            check_value("out_data", out_data, exp_beat[DW+1:2]);
            check_value("out_last", out_last, exp_beat[1]);
            check_value("out_drop", out_drop, exp_beat[0]);
            beats       = beats + 1;
            total_beats = total_beats + 1;
            if (exp_beat[0]) begin
                marked = marked + 1;
            end
        end
    endtask

    // sampled mid cycle, where inputs and outputs are settled
    always @(negedge packet_in) begin
        if (!rst_n) begin
            for (int p = 0; p < NP; p++) begin
                bucket[p]   = 0;
                dec_hold[p] = 0;
                off_hold[p] = 0;
            end
            expected.delete();
            sop         = 1'b1;
            pkt_drop    = 1'b0;
            beats       = 0;
            marked      = 0;
            test_errs   = 0;
            total_beats = 0;
            tests_run   = 0;
            err_count   = 0;
        end else begin
            update_leak();
            if (out_valid && out_ready) begin
                check_output();
            end
            if (in_valid && in_ready) begin
                take_input();
            end
            if (test_done) begin
                $display("test %0d %s: %0d beats, %0d marked, %0d errors",
                         test_id, test_name(test_id), beats, marked, test_errs);
                tests_run = tests_run + 1;
                beats     = 0;
                marked    = 0;
                test_errs = 0;
            end
            if (report) begin
                if (expected.size() != 0) begin
                    $display("%0d input beats never came out of the DUT", expected.size());
                    count_error();
                end
                $display("%0d tests, %0d beats checked, %0d errors",
                         tests_run, total_beats, err_count);
            end
        end
    end

endmodule

`default_nettype wire

//--- test/policer_tb.sv
/* stimulus comes from the packet table below; control only changes once the
   pipeline is empty, and leak rows use a decrement that empties any bucket */
`timescale 1ns/10ps
`default_nettype none

`include "policer_config.svh"

module policer_tb;

    localparam int NP       = `POLICER_NUM_PORTS;
    localparam int BW       = `POLICER_BUCKET_W;
    localparam int MAX_ROWS = 40;

    logic                       packet_in;
    logic                       rst_n;
    logic                       in_valid;
    logic                       in_ready;
    logic [`POLICER_DATA_W-1:0] in_data;
    logic                       in_last;
    policer_pkg::port_t         in_port;
    policer_pkg::len_t          in_len;
    logic                       out_valid;
    logic                       out_ready;
    logic [`POLICER_DATA_W-1:0] out_data;
    logic                       out_last;
    logic                       out_drop;
    logic [NP-1:0]              enable;
    policer_pkg::bucket_t       decrement [NP-1:0];
    policer_pkg::bucket_t       threshold [NP-1:0];

    // monitor hooks
    logic test_done;
    int   test_id;
    logic report;
    int   err_count;

    // one row per packet; a row without beats only sets control and waits
    int                   row_test  [MAX_ROWS];
    int                   row_port  [MAX_ROWS];
    int                   row_len   [MAX_ROWS];
    int                   row_beats [MAX_ROWS];
    int                   row_gap   [MAX_ROWS];
    logic                 row_stall [MAX_ROWS];
    logic [NP-1:0]        row_en    [MAX_ROWS];
    logic [NP*BW-1:0]     row_thr   [MAX_ROWS];
    policer_pkg::bucket_t row_dec   [MAX_ROWS];
    int                   num_rows;
    int                   table_cycles;

    logic             stall_mode;
    logic [NP*BW-1:0] cur_thr;
    int               in_cnt;
    int               out_cnt;
    int               budget_cycles;
    int               seed;

    policer_top dut0 (.*);

    policer_monitor mon0 (.*);

    initial begin
        packet_in = 1'b0;
        forever #10 packet_in = ~packet_in;
    end

    // random stalls only while the row asks for them
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge packet_in);
            #1;
            out_ready = stall_mode ? (($urandom % 3) != 0) : 1'b1;
        end
    end

    always @(negedge packet_in) begin
        if (out_valid && out_ready) begin
            out_cnt <= out_cnt + 1;
        end
    end

    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge packet_in);
        $display("timeout: the run did not finish within %0d cycles", budget_cycles);
        $display("Test failed");
        $finish;
    end

    function automatic logic [NP*BW-1:0] pack_thresholds(input int t0, input int t1,
                                                         input int t2, input int t3);
        return {BW'(t3), BW'(t2), BW'(t1), BW'(t0)};
    endfunction

    task automatic add_row(input int test, input int port, input int len, input int beats,
                           input int gap, input logic stall, input logic [NP-1:0] en,
                           input logic [NP*BW-1:0] thr, input policer_pkg::bucket_t dec);
        row_test[num_rows]  = test;
        row_port[num_rows]  = port;
        row_len[num_rows]   = len;
        row_beats[num_rows] = beats;
        row_gap[num_rows]   = gap;
        row_stall[num_rows] = stall;
        row_en[num_rows]    = en;
        row_thr[num_rows]   = thr;
        row_dec[num_rows]   = dec;
        table_cycles        = table_cycles + beats + gap + 1;
        num_rows            = num_rows + 1;
    endtask

    task automatic build_table;
        logic [NP*BW-1:0] thr_flat;
        logic [NP*BW-1:0] thr_steps;
        logic [NP*BW-1:0] thr_mixed;
        thr_flat  = pack_thresholds(300, 300, 300, 300);
        thr_steps = pack_thresholds(100, 200, 300, 400);
        thr_mixed = pack_thresholds(150, 200, 300, 250);
        // port 0 fills to exactly 300, then is marked
        add_row(1, 0, 100, 2, 0, 1'b0, 4'hf, thr_flat, 16'h0);
        add_row(1, 0, 100, 3, 1, 1'b0, 4'hf, thr_flat, 16'h0);
        add_row(1, 0, 100, 1, 2, 1'b0, 4'hf, thr_flat, 16'h0);
        add_row(1, 0, 50, 2, 0, 1'b0, 4'hf, thr_flat, 16'h0);
        add_row(1, 0, 20, 4, 1, 1'b0, 4'hf, thr_flat, 16'h0);
        // empty all buckets first
        add_row(2, 0, 0, 0, 60, 1'b0, 4'hf, thr_steps, 16'hffff);
        for (int r = 0; r < 3; r++) begin
            for (int p = 0; p < NP; p++) begin
                add_row(2, p, 90, 1 + (p + r) % 3, p % 2, 1'b0, 4'hf, thr_steps, 16'h0);
            end
        end
        // port 2 starts at 270 of 300
        add_row(3, 2, 100, 2, 1, 1'b0, 4'hf, thr_steps, 16'h0);
        add_row(3, 2, 500, 3, 1, 1'b0, 4'b1011, thr_steps, 16'h0);
        add_row(3, 2, 500, 1, 0, 1'b0, 4'b1011, thr_steps, 16'h0);
        add_row(3, 2, 250, 2, 1, 1'b0, 4'hf, thr_steps, 16'h0);
        add_row(3, 2, 100, 1, 0, 1'b0, 4'hf, thr_steps, 16'h0);
        // port 1 starts at 180 of 200
        add_row(4, 1, 100, 2, 0, 1'b0, 4'hf, thr_steps, 16'h0);
        add_row(4, 1, 0, 0, 60, 1'b0, 4'hf, thr_steps, 16'hffff);
        add_row(4, 1, 100, 3, 1, 1'b0, 4'hf, thr_steps, 16'h0);
        for (int k = 0; k < 8; k++) begin
            add_row(5, (k % 2 == 0) ? 0 : 3, 70, 4, k % 3 == 2, 1'b1, 4'hf, thr_mixed,
                    16'h0);
        end
    endtask

    task automatic apply_control(input int i);
        enable     = row_en[i];
        cur_thr    = row_thr[i];
        stall_mode = row_stall[i];
        for (int p = 0; p < NP; p++) begin
            threshold[p] = row_thr[i][p*BW +: BW];
            decrement[p] = row_dec[i];
        end
    endtask

    function automatic logic control_differs(input int i);
        return enable != row_en[i] || cur_thr != row_thr[i]
            || decrement[0] != row_dec[i] || stall_mode != row_stall[i];
    endfunction

    task automatic next_cycle;
        @(posedge packet_in);
        #1;
    endtask

    task automatic wait_drain;
        @(negedge packet_in);
        while (out_cnt != in_cnt) begin
            @(negedge packet_in);
        end
        next_cycle();
    endtask

    task automatic send_beat(input int row, input logic first, input logic last);
        logic taken;
        in_valid = 1'b1;
        in_data  = $urandom;
        in_last  = last;
        // later beats carry junk sideband, which the DUT must ignore
        in_port  = first ? policer_pkg::port_t'(row_port[row]) : policer_pkg::port_t'($urandom);
        in_len   = first ? policer_pkg::len_t'(row_len[row]) : policer_pkg::len_t'($urandom);
        taken    = 1'b0;
        while (!taken) begin
            @(negedge packet_in);
            taken = in_ready;
            next_cycle();
        end
        in_valid = 1'b0;
        in_cnt   = in_cnt + 1;
    endtask

    task automatic pulse_done;
        test_done = 1'b1;
        next_cycle();
        test_done = 1'b0;
    endtask

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        in_last      = 1'b0;
        in_port      = '0;
        in_len       = '0;
        test_done    = 1'b0;
        report       = 1'b0;
        in_cnt       = 0;
        num_rows     = 0;
        table_cycles = 0;
        seed         = 32'h42a8_3efa;
        void'($urandom(seed));
        build_table();
        apply_control(0);
        test_id       = row_test[0];
        budget_cycles = 4 * (table_cycles + 8);
        repeat (3) @(posedge packet_in);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < num_rows; i++) begin
            if (row_test[i] != test_id) begin
                wait_drain();
                pulse_done();
                test_id = row_test[i];
            end
            if (control_differs(i)) begin
                wait_drain();
                apply_control(i);
            end
            for (int b = 0; b < row_beats[i]; b++) begin
                send_beat(i, b == 0, b == row_beats[i] - 1);
            end
            repeat (row_gap[i]) next_cycle();
        end
        wait_drain();
        pulse_done();
        report = 1'b1;
        next_cycle();
        report = 1'b0;
        next_cycle();
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
logic/policer_pkg.sv
logic/stream_stage.sv
logic/bucket_table.sv
logic/bucket_arbiter.sv
logic/leak_engine.sv
logic/policer_check.sv
logic/policer_top.sv
test/policer_monitor.sv
test/policer_tb.sv
